// File: rtl/pmu_pkg.sv
// PMU package with widths, register map, AHB and register-write structs and types
package pmu_pkg;

    // ----------------------------------------------------------
    // Widths and sizes
    // ----------------------------------------------------------
    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int N_COUNTERS = 4;
    localparam int N_REGS     = 8;
    localparam int REG_IDX_W  = 3;
    // Word addressing, two byte-offset bits below the index
    localparam int BYTE_OFF_W = 2;
    localparam int CNT_IDX_W  = $clog2(N_COUNTERS);
    // Masked sum carries one spare bit above the worst case
    localparam int SUM_W      = DATA_W + $clog2(N_COUNTERS) + 1;

    // Basic vector types
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [N_COUNTERS-1:0] event_vec_t;
    typedef data_t [N_COUNTERS-1:0] cnt_array_t;

    // ----------------------------------------------------------
    // Register map, word indices
    // ----------------------------------------------------------
    localparam reg_idx_t REG_CFG    = 3'd0;
    // Counters occupy REG_CNT0 .. REG_CNT0+N_COUNTERS-1
    localparam reg_idx_t REG_CNT0   = 3'd1;
    localparam reg_idx_t REG_OVF    = 3'd5;
    localparam reg_idx_t REG_QLIMIT = 3'd6;
    localparam reg_idx_t REG_QMASK  = 3'd7;

    // Configuration register bits
    localparam int CFG_EN_BIT   = 0;
    localparam int CFG_SRST_BIT = 1;

    // AHB transfer types and response
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_BUSY   = 2'b01;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;
    localparam logic       HRESP_OKAY    = 1'b0;

    // ----------------------------------------------------------
    // Bus and internal structs
    // ----------------------------------------------------------
    typedef struct packed {
        logic              sel;
        logic [1:0]        trans;
        logic              write;
        logic [ADDR_W-1:0] addr;
        data_t             wdata;
    } ahb_req_t;

    typedef struct packed {
        logic  ready;
        logic  resp;
        data_t rdata;
    } ahb_rsp_t;

    // Decoded register write, valid in the data phase only
    typedef struct packed {
        logic     valid;
        reg_idx_t index;
        data_t    data;
    } reg_wr_t;

    // Data-phase state of the slave
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_XFER
    } ahb_state_e;

endpackage

// File: rtl/pmu_ahb_ctrl.sv
// AHB-lite slave control with address-phase registers, write decode and read mux
module pmu_ahb_ctrl
    import pmu_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  ahb_req_t   ahb_req_i,
    output ahb_rsp_t   ahb_rsp_o,
    output reg_wr_t    reg_wr_o,
    input  data_t      cfg_i,
    input  data_t      ovf_i,
    input  data_t      qlimit_i,
    input  data_t      qmask_i,
    input  cnt_array_t counters_i
);

    ahb_state_e                   state_q;
    ahb_state_e                   state_d;
    logic                         sel_q;
    logic                         write_q;
    logic [ADDR_W-1:0]            addr_q;
    logic                         accept;
    logic                         data_phase;
    logic [ADDR_W-BYTE_OFF_W-1:0] word_idx;
    reg_idx_t                     reg_idx;
    reg_idx_t                     cnt_off;
    logic                         invalid_idx;
    data_t                        rd_word;

    // ----------------------------------------------------------
    // Address phase
    // ----------------------------------------------------------
    // Only NONSEQ and SEQ carry a real transfer
    assign accept = ahb_req_i.sel &&
                    (ahb_req_i.trans == HTRANS_NONSEQ || ahb_req_i.trans == HTRANS_SEQ);

    always_comb begin
        if (accept) begin
            state_d = ST_XFER;
        end else if (ahb_req_i.sel && ahb_req_i.trans == HTRANS_BUSY) begin
            state_d = ST_BUSY;
        end else begin
            state_d = ST_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= ST_IDLE;
            sel_q   <= 1'b0;
            write_q <= 1'b0;
        end else begin
            state_q <= state_d;
            sel_q   <= ahb_req_i.sel;
            // Write flag only kept for accepted transfers
            write_q <= (state_d == ST_XFER) && ahb_req_i.write;
        end
    end

    // Address holds its last accepted value between transfers
    always_ff @(posedge clk_i) begin
        if (state_d == ST_XFER) begin
            addr_q <= ahb_req_i.addr;
        end
    end

    // ----------------------------------------------------------
    // Data phase
    // ----------------------------------------------------------
    assign data_phase = (state_q == ST_XFER) && sel_q;

    // Full word index, so addresses past the map are caught
    assign word_idx    = addr_q[ADDR_W-1:BYTE_OFF_W];
    assign invalid_idx = (word_idx >= N_REGS);
    assign reg_idx     = word_idx[REG_IDX_W-1:0];
    assign cnt_off     = reg_idx - REG_CNT0;

    // Write strobe towards the datapath blocks
    assign reg_wr_o.valid = data_phase && write_q && !invalid_idx;
    assign reg_wr_o.index = reg_idx;
    assign reg_wr_o.data  = ahb_req_i.wdata;

    // Register select, counters fill the remaining indices
    always_comb begin
        case (reg_idx)
            REG_CFG:    rd_word = cfg_i;
            REG_OVF:    rd_word = ovf_i;
            REG_QLIMIT: rd_word = qlimit_i;
            REG_QMASK:  rd_word = qmask_i;
            default:    rd_word = counters_i[cnt_off[CNT_IDX_W-1:0]];
        endcase
    end

    // No wait states and no error responses
    assign ahb_rsp_o.ready = 1'b1;
    assign ahb_rsp_o.resp  = HRESP_OKAY;
    // Zero outside a valid read data phase
    assign ahb_rsp_o.rdata = (data_phase && !write_q && !invalid_idx) ? rd_word : '0;

    // ----------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------
    // Accepted write inside the map strobes its register one cycle later with no read data
    a_xfer_completes: assert property (@(posedge clk_i) disable iff (!rstn_i)
        accept && ahb_req_i.write && (ahb_req_i.addr[ADDR_W-1:BYTE_OFF_W] < N_REGS) |=>
            reg_wr_o.valid &&
            (reg_wr_o.index == $past(ahb_req_i.addr[BYTE_OFF_W +: REG_IDX_W])) &&
            (ahb_rsp_o.rdata == '0));

    // Write strobe only follows an accepted write address phase
    a_wr_in_xfer: assert property (@(posedge clk_i) disable iff (!rstn_i)
        reg_wr_o.valid |-> (state_q == ST_XFER) && $past(accept && ahb_req_i.write));

endmodule

// File: rtl/pmu_counters.sv
// Configuration register and event counter array with soft reset and bus writes
module pmu_counters
    import pmu_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  reg_wr_t    reg_wr_i,
    input  event_vec_t events_i,
    output data_t      cfg_o,
    output cnt_array_t counters_o,
    output event_vec_t wrap_o
);

    data_t      cfg_q;
    data_t      cfg_d;
    cnt_array_t cnt_q;
    cnt_array_t cnt_d;
    logic       cfg_wr;
    logic       cnt_en;
    logic       soft_rst;
    event_vec_t cnt_wr;
    event_vec_t inc;

    assign cfg_wr   = reg_wr_i.valid && (reg_wr_i.index == REG_CFG);
    assign cnt_en   = cfg_q[CFG_EN_BIT];
    assign soft_rst = cfg_q[CFG_SRST_BIT];

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------
    always_comb begin
        // Soft reset bit drops by itself unless rewritten
        cfg_d               = cfg_q;
        cfg_d[CFG_SRST_BIT] = 1'b0;
        if (cfg_wr) begin
            cfg_d               = '0;
            cfg_d[CFG_EN_BIT]   = reg_wr_i.data[CFG_EN_BIT];
            cfg_d[CFG_SRST_BIT] = reg_wr_i.data[CFG_SRST_BIT];
        end

        // Priority per counter: bus write, soft reset, increment
        for (int n = 0; n < N_COUNTERS; n++) begin
            cnt_wr[n] = reg_wr_i.valid && (reg_wr_i.index == reg_idx_t'(REG_CNT0 + n));
            inc[n]    = !cnt_wr[n] && !soft_rst && cnt_en && events_i[n];
            if (cnt_wr[n]) begin
                cnt_d[n] = reg_wr_i.data;
            end else if (soft_rst) begin
                cnt_d[n] = '0;
            end else if (inc[n]) begin
                cnt_d[n] = cnt_q[n] + 1'b1;
            end else begin
                cnt_d[n] = cnt_q[n];
            end
            // All ones plus one rolls over to zero
            wrap_o[n] = inc[n] && (cnt_q[n] == '1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cfg_q <= '0;
            cnt_q <= '0;
        end else begin
            cfg_q <= cfg_d;
            cnt_q <= cnt_d;
        end
    end

    assign cfg_o      = cfg_q;
    assign counters_o = cnt_q;

    // Soft reset lasts one cycle and leaves every counter at zero
    a_soft_rst_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        soft_rst && !reg_wr_i.valid |=> !soft_rst && (counters_o == '0));

endmodule

// File: rtl/pmu_overflow.sv
// Sticky overflow status register with write-one-to-clear and overflow interrupt
module pmu_overflow
    import pmu_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  reg_wr_t    reg_wr_i,
    input  event_vec_t wrap_i,
    output data_t      ovf_o,
    output logic       intr_overflow_o
);

    event_vec_t flags_q;
    event_vec_t flags_d;
    event_vec_t clr;
    logic       intr_q;

    // Ones written to the status word clear the matching flags
    always_comb begin
        clr = '0;
        if (reg_wr_i.valid && (reg_wr_i.index == REG_OVF)) begin
            clr = reg_wr_i.data[N_COUNTERS-1:0];
        end
        // A wrap in the same cycle beats the clear
        flags_d = (flags_q & ~clr) | wrap_i;
    end

    // ----------------------------------------------------------
    // Flags and interrupt
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            flags_q <= '0;
            intr_q  <= 1'b0;
        end else begin
            flags_q <= flags_d;
            // Interrupt lags the flags by one cycle
            intr_q  <= |flags_q;
        end
    end

    assign ovf_o           = data_t'(flags_q);
    assign intr_overflow_o = intr_q;

endmodule

// File: rtl/pmu_quota.sv
// Quota limit and mask registers, masked counter sum and quota interrupt
module pmu_quota
    import pmu_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  reg_wr_t    reg_wr_i,
    input  cnt_array_t counters_i,
    output data_t      qlimit_o,
    output data_t      qmask_o,
    output logic       intr_quota_o
);

    data_t              qlimit_q;
    event_vec_t         qmask_q;
    logic [SUM_W-1:0]   masked_sum;
    logic               intr_q;

    // ----------------------------------------------------------
    // Registers
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            qlimit_q <= '0;
            qmask_q  <= '0;
            intr_q   <= 1'b0;
        end else begin
            if (reg_wr_i.valid && (reg_wr_i.index == REG_QLIMIT)) begin
                qlimit_q <= reg_wr_i.data;
            end
            // Only one mask bit per counter is kept
            if (reg_wr_i.valid && (reg_wr_i.index == REG_QMASK)) begin
                qmask_q <= reg_wr_i.data[N_COUNTERS-1:0];
            end
            intr_q <= (masked_sum > SUM_W'(qlimit_q));
        end
    end

    // Sum of selected counters, wide enough to never overflow
    always_comb begin
        masked_sum = '0;
        for (int n = 0; n < N_COUNTERS; n++) begin
            if (qmask_q[n]) begin
                masked_sum = masked_sum + SUM_W'(counters_i[n]);
            end
        end
    end

    assign qlimit_o     = qlimit_q;
    assign qmask_o      = data_t'(qmask_q);
    assign intr_quota_o = intr_q;

endmodule

// File: rtl/pmu_top.sv
// PMU top level with AHB-lite port, counters, overflow and quota blocks
module pmu_top
    import pmu_pkg::*;
(
    input  logic              clk_i,
    input  logic              rstn_i,
    // AHB-lite slave port
    input  logic              hsel_i,
    input  logic [1:0]        htrans_i,
    input  logic              hwrite_i,
    input  logic [ADDR_W-1:0] haddr_i,
    input  data_t             hwdata_i,
    output logic              hready_o,
    output logic              hresp_o,
    output data_t             hrdata_o,
    // Events and interrupts
    input  event_vec_t        events_i,
    output logic              intr_overflow_o,
    output logic              intr_quota_o
);

    ahb_req_t   ahb_req;
    ahb_rsp_t   ahb_rsp;
    reg_wr_t    reg_wr;
    data_t      cfg;
    data_t      ovf;
    data_t      qlimit;
    data_t      qmask;
    cnt_array_t counters;
    event_vec_t wrap;

    // ----------------------------------------------------------
    // Bus packing
    // ----------------------------------------------------------
    assign ahb_req = '{sel: hsel_i, trans: htrans_i, write: hwrite_i,
                       addr: haddr_i, wdata: hwdata_i};

    assign hready_o = ahb_rsp.ready;
    assign hresp_o  = ahb_rsp.resp;
    assign hrdata_o = ahb_rsp.rdata;

    // ----------------------------------------------------------
    // Blocks
    // ----------------------------------------------------------
    pmu_ahb_ctrl u_ahb_ctrl (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .ahb_req_i  (ahb_req),
        .ahb_rsp_o  (ahb_rsp),
        .reg_wr_o   (reg_wr),
        .cfg_i      (cfg),
        .ovf_i      (ovf),
        .qlimit_i   (qlimit),
        .qmask_i    (qmask),
        .counters_i (counters)
    );

    pmu_counters u_counters (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .reg_wr_i   (reg_wr),
        .events_i   (events_i),
        .cfg_o      (cfg),
        .counters_o (counters),
        .wrap_o     (wrap)
    );

    pmu_overflow u_overflow (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .reg_wr_i        (reg_wr),
        .wrap_i          (wrap),
        .ovf_o           (ovf),
        .intr_overflow_o (intr_overflow_o)
    );

    pmu_quota u_quota (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .reg_wr_i     (reg_wr),
        .counters_i   (counters),
        .qlimit_o     (qlimit),
        .qmask_o      (qmask),
        .intr_quota_o (intr_quota_o)
    );

endmodule

// File: testbench/pmu_checker.sv
// PMU checker with register reference model, read data and interrupt comparison
module pmu_checker
    import pmu_pkg::*;
(
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              hsel_i,
    input  logic [1:0]        htrans_i,
    input  logic              hwrite_i,
    input  logic [ADDR_W-1:0] haddr_i,
    input  data_t             hwdata_i,
    input  event_vec_t        events_i,
    input  logic              hready_i,
    input  logic              hresp_i,
    input  data_t             hrdata_i,
    input  logic              intr_overflow_i,
    input  logic              intr_quota_i,
    output int                errors_o,
    output int                checks_o
);

    // Modelled register state plus the pending data phase
    typedef struct packed {
        logic              en;
        logic              srst;
        cnt_array_t        cnt;
        event_vec_t        flags;
        logic              intr_ovf;
        data_t             qlimit;
        event_vec_t        qmask;
        logic              intr_q;
        logic              dp_valid;
        logic              dp_write;
        logic [ADDR_W-1:0] dp_addr;
    } model_t;

    model_t model;
    data_t  exp_rdata;
    int     errors = 0;
    int     checks = 0;

    // Register contents as software sees them, zero past the map
    function automatic data_t reg_value(model_t m, int idx);
        data_t v;
        v = '0;
        if (idx == 0) begin
            v[1:0] = {m.srst, m.en};
        end else if (idx == 5) begin
            v[N_COUNTERS-1:0] = m.flags;
        end else if (idx == 6) begin
            v = m.qlimit;
        end else if (idx == 7) begin
            v[N_COUNTERS-1:0] = m.qmask;
        end else begin
            for (int c = 0; c < N_COUNTERS; c++) begin
                if (idx == c + 1) begin
                    v = m.cnt[c];
                end
            end
        end
        return v;
    endfunction

    // ----------------------------------------------------------
    // Reference model, one clock edge
    // ----------------------------------------------------------
    function automatic model_t next_model(model_t m, logic sel, logic [1:0] trans,
                                          logic write, logic [ADDR_W-1:0] addr,
                                          data_t wdata, event_vec_t ev);
        model_t      n;
        int          widx;
        logic        wr;
        logic [63:0] sum;
        n    = m;
        widx = int'(m.dp_addr[ADDR_W-1:2]);
        wr   = m.dp_valid && m.dp_write && (widx < N_REGS);
        // Soft reset bit lasts one cycle unless rewritten
        n.srst = 1'b0;
        if (wr && widx == 0) begin
            n.en   = wdata[0];
            n.srst = wdata[1];
        end
        // Clear first so a wrap in the same cycle wins
        if (wr && widx == 5) begin
            n.flags = m.flags & ~wdata[N_COUNTERS-1:0];
        end
        for (int c = 0; c < N_COUNTERS; c++) begin
            if (wr && widx == c + 1) begin
                n.cnt[c] = wdata;
            end else if (m.srst) begin
                n.cnt[c] = '0;
            end else if (m.en && ev[c]) begin
                n.cnt[c] = m.cnt[c] + 32'd1;
                if (m.cnt[c] == '1) begin
                    n.flags[c] = 1'b1;
                end
            end
        end
        n.intr_ovf = |m.flags;
        if (wr && widx == 6) begin
            n.qlimit = wdata;
        end
        if (wr && widx == 7) begin
            n.qmask = wdata[N_COUNTERS-1:0];
        end
        // Quota compares the old sum against the old limit
        sum = '0;
        for (int c = 0; c < N_COUNTERS; c++) begin
            if (m.qmask[c]) begin
                sum = sum + 64'(m.cnt[c]);
            end
        end
        n.intr_q = sum > 64'(m.qlimit);
        // Address phase seen now becomes the next data phase
        n.dp_valid = sel && (trans == HTRANS_NONSEQ || trans == HTRANS_SEQ);
        n.dp_write = write;
        n.dp_addr  = addr;
        return n;
    endfunction

    task automatic compare_value(input string what, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at time %0t: %s is 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
        end
    endtask

    // ----------------------------------------------------------
    // Comparison at every rising edge
    // ----------------------------------------------------------
    always @(posedge clk_i) begin
        if (!rstn_i) begin
            model = '0;
        end else begin
            // Reads outside a valid data phase return zero
            exp_rdata = '0;
            if (model.dp_valid && !model.dp_write) begin
                exp_rdata = reg_value(model, int'(model.dp_addr[ADDR_W-1:2]));
            end
            compare_value("hrdata", hrdata_i, exp_rdata);
            compare_value("ready and resp", data_t'({hready_i, hresp_i}), data_t'(2'b10));
            compare_value("intr_overflow", data_t'(intr_overflow_i), data_t'(model.intr_ovf));
            compare_value("intr_quota", data_t'(intr_quota_i), data_t'(model.intr_q));
            model = next_model(model, hsel_i, htrans_i, hwrite_i, haddr_i, hwdata_i, events_i);
        end
    end

    assign errors_o = errors;
    assign checks_o = checks;

endmodule

// File: testbench/tb_pmu.sv
// PMU testbench with clock, reset, AHB bus tasks, test sequence and watchdog
module tb_pmu
    import pmu_pkg::*;
();

    // Cycle budget per test, summed for the watchdog
    localparam int RESET_CYCLES    = 3;
    localparam int TEST_CYCLES     = 80 + 40 + 480 + 100 + 380;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 200;

    logic              clk_i;
    logic              rstn_i;
    logic              hsel_i;
    logic [1:0]        htrans_i;
    logic              hwrite_i;
    logic [ADDR_W-1:0] haddr_i;
    data_t             hwdata_i;
    logic              hready_o;
    logic              hresp_o;
    data_t             hrdata_o;
    event_vec_t        events_i;
    logic              intr_overflow_o;
    logic              intr_quota_o;
    int                chk_errors;
    int                chk_checks;
    int                tb_errors = 0;
    int                test_num = 1;
    int                errs_seen = 0;
    data_t             rd_data;

    pmu_top u_pmu_top (.*);

    pmu_checker u_checker (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .hsel_i          (hsel_i),
        .htrans_i        (htrans_i),
        .hwrite_i        (hwrite_i),
        .haddr_i         (haddr_i),
        .hwdata_i        (hwdata_i),
        .events_i        (events_i),
        .hready_i        (hready_o),
        .hresp_i         (hresp_o),
        .hrdata_i        (hrdata_o),
        .intr_overflow_i (intr_overflow_o),
        .intr_quota_i    (intr_quota_o),
        .errors_o        (chk_errors),
        .checks_o        (chk_checks)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------
    // Bus and stimulus tasks
    // ----------------------------------------------------------
    // One NONSEQ address phase, returns at the start of the data phase
    task automatic address_phase(input int idx, input logic write);
        @(negedge clk_i);
        hsel_i   = 1'b1;
        htrans_i = HTRANS_NONSEQ;
        hwrite_i = write;
        haddr_i  = ADDR_W'(idx) << 2;
        @(negedge clk_i);
        hsel_i   = 1'b0;
        htrans_i = HTRANS_IDLE;
        hwrite_i = 1'b0;
    endtask

    task automatic ahb_write(input int idx, input data_t data);
        address_phase(idx, 1'b1);
        hwdata_i = data;
    endtask

    // Read data is stable in the middle of the data phase
    task automatic ahb_read(input int idx, output data_t data);
        address_phase(idx, 1'b0);
        data = hrdata_o;
    endtask

    task automatic expect_read(input int idx, input data_t exp);
        data_t got;
        ahb_read(idx, got);
        if (got !== exp) begin
            tb_errors++;
            $display("mismatch at time %0t: register %0d read 0x%08h, expected 0x%08h",
                     $time, idx, got, exp);
        end
    endtask

    task automatic random_events(input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            events_i = event_vec_t'($urandom());
        end
        @(negedge clk_i);
        events_i = '0;
    endtask

    task automatic report_error(input string msg);
        tb_errors++;
        $display("error at time %0t: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        int now;
        now = tb_errors + chk_errors;
        $display("test %0d %s: %s, %0d errors", test_num, name,
                 (now == errs_seen) ? "ok" : "failed", now - errs_seen);
        test_num++;
        errs_seen = now;
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        void'($urandom(34));
        rstn_i   = 1'b0;
        hsel_i   = 1'b0;
        htrans_i = HTRANS_IDLE;
        hwrite_i = 1'b0;
        haddr_i  = '0;
        hwdata_i = '0;
        events_i = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rstn_i = 1'b1;

        // Reset values and indices past the map
        for (int i = 0; i < N_REGS; i++) expect_read(i, '0);
        expect_read(8, '0);
        expect_read(64, '0);
        ahb_write(8, '1);
        ahb_write(15, '1);
        for (int i = 0; i < N_REGS; i++) expect_read(i, '0);
        if (intr_overflow_o || intr_quota_o) report_error("interrupt high after reset");
        end_test("reset state");

        ahb_write(int'(REG_CFG), 32'h1);
        expect_read(int'(REG_CFG), 32'h1);
        ahb_write(int'(REG_QLIMIT), 32'hA5C3_0F96);
        expect_read(int'(REG_QLIMIT), 32'hA5C3_0F96);
        // Index past the map shares its low bits with QLIMIT and still reads zero
        expect_read(int'(REG_QLIMIT) + N_REGS, '0);
        // Mask keeps its low four bits only
        ahb_write(int'(REG_QMASK), 32'hFFFF_FFF5);
        expect_read(int'(REG_QMASK), 32'h5);
        ahb_write(int'(REG_CFG), '0);
        ahb_write(int'(REG_QMASK), '0);
        ahb_write(int'(REG_QLIMIT), '0);
        end_test("config readback");

        random_events(200);
        for (int c = 0; c < N_COUNTERS; c++) expect_read(int'(REG_CNT0) + c, '0);
        ahb_write(int'(REG_CFG), 32'h1);
        random_events(200);
        // Counts are compared with the model by the checker
        for (int c = 0; c < N_COUNTERS; c++) begin
            ahb_read(int'(REG_CNT0) + c, rd_data);
            if (rd_data == '0) report_error("counter stayed at zero with counting enabled");
        end
        ahb_write(int'(REG_CFG), 32'h3);
        for (int c = 0; c < N_COUNTERS; c++) expect_read(int'(REG_CNT0) + c, '0);
        expect_read(int'(REG_CFG), 32'h1);
        ahb_write(int'(REG_CFG), '0);
        end_test("event counting");

        // Counter 2 sixteen increments short of wrapping
        ahb_write(int'(REG_CNT0) + 2, 32'hFFFF_FFF0);
        events_i = 4'b0100;
        ahb_write(int'(REG_CFG), 32'h1);
        for (int i = 0; i < 40 && !intr_overflow_o; i++) @(negedge clk_i);
        if (!intr_overflow_o) report_error("overflow interrupt did not rise within 40 cycles");
        events_i = '0;
        expect_read(int'(REG_OVF), 32'h4);
        ahb_write(int'(REG_OVF), 32'h4);
        expect_read(int'(REG_OVF), '0);
        if (intr_overflow_o) report_error("overflow interrupt still high after clearing");
        ahb_write(int'(REG_CFG), '0);
        end_test("counter overflow");

        ahb_write(int'(REG_CFG), 32'h2);
        ahb_write(int'(REG_QMASK), 32'h3);
        ahb_write(int'(REG_QLIMIT), 32'd150);
        ahb_write(int'(REG_CFG), 32'h1);
        random_events(200);
        if (!intr_quota_o) report_error("quota interrupt did not rise above the limit");
        // Rewrite counters 0 and 1 well below the limit
        ahb_write(int'(REG_CNT0), 32'd10);
        ahb_write(int'(REG_CNT0) + 1, 32'd20);
        repeat (2) @(negedge clk_i);
        if (intr_quota_o) report_error("quota interrupt still high below the limit");
        random_events(100);
        ahb_write(int'(REG_CFG), '0);
        end_test("quota check");

        @(negedge clk_i);
        $display("summary: %0d tests, %0d checker checks, %0d errors",
                 test_num - 1, chk_checks, tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog against a stalled sequence
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: build.f
rtl/pmu_pkg.sv
rtl/pmu_ahb_ctrl.sv
rtl/pmu_counters.sv
rtl/pmu_overflow.sv
rtl/pmu_quota.sv
rtl/pmu_top.sv
testbench/pmu_checker.sv
testbench/tb_pmu.sv

// File: Makefile
# Verilator build and run of the PMU testbench

VERILATOR ?= verilator
TOP       ?= tb_pmu
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
